// ==== hw/soc_bus_pkg.sv ====
// Fabric address map and widths

`default_nettype none

package soc_bus_pkg;

    // ==============================
    // Widths
    // ==============================

    // Data and address width
    localparam int xlen = 32;

    // Main memory geometry
    localparam int mem_words      = 1024;
    localparam int mem_index_bits = 10;

    // ==============================
    // Address map
    // ==============================

    // Set for the system region at 0x1000
    localparam int system_bit = 12;

    // Sub-block code in address bits 11:8
    localparam logic [3:0] gpio_select = 4'h0;

    // GPIO word offsets taken from address bits 7:2
    localparam logic [5:0] gpio_out_offset = 6'd0;
    localparam logic [5:0] gpio_in_offset  = 6'd1;
    localparam logic [5:0] gpio_dir_offset = 6'd2;

endpackage

`default_nettype wire

// ==== hw/main_memory.sv ====
// Main memory with byte write mask

`timescale 1ns/10ps
`default_nettype none

module main_memory
    import soc_bus_pkg::*;
(
    input  logic              clk,
    input  logic [xlen-1:0]   addr,
    input  logic [xlen-1:0]   wr_data,
    input  logic              en,
    input  logic              wr_en,
    input  logic [xlen/8-1:0] wr_mask,
    output logic [xlen-1:0]   rd_data
);

    logic [xlen-1:0]           mem [mem_words];
    logic [mem_index_bits-1:0] index;

    // Word index from address bits 11:2
    assign index = addr[mem_index_bits+1:2];

    // ==============================
    // Read port
    // ==============================

    // Old word is returned even on a write
    always_ff @(posedge clk) begin
        if (en) begin
            rd_data <= mem[index];
        end
    end

    // ==============================
    // Write port
    // ==============================

    always_ff @(posedge clk) begin
        if (en && wr_en) begin
            for (int b = 0; b < xlen / 8; b++) begin
                // Untouched lanes keep their contents
                if (wr_mask[b]) begin
                    mem[index][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/gpio_block.sv ====
// GPIO registers and pin sync

`timescale 1ns/10ps
`default_nettype none

module gpio_block
    import soc_bus_pkg::*;
(
    input  logic            clk,
    input  logic            rstz,
    input  logic [xlen-1:0] addr,
    input  logic [xlen-1:0] wr_data,
    input  logic            en,
    input  logic            wr_en,
    input  logic [xlen-1:0] pins_in,
    output logic [xlen-1:0] rd_data,
    output logic [xlen-1:0] pins_out,
    output logic [xlen-1:0] pins_oe
);

    logic [5:0]      offset;
    logic [xlen-1:0] out_reg;
    logic [xlen-1:0] dir_reg;
    logic [xlen-1:0] sync_meta;
    logic [xlen-1:0] sync_pins;

    assign offset = addr[7:2];

    // ==============================
    // Control registers
    // ==============================

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            out_reg <= '0;
            dir_reg <= '0;
        end else if (en && wr_en) begin
            if (offset == gpio_out_offset) begin
                out_reg <= wr_data;
            end
            if (offset == gpio_dir_offset) begin
                dir_reg <= wr_data;
            end
        end
    end

    assign pins_out = out_reg;
    assign pins_oe  = dir_reg;

    // Two-flop synchronizer for the input pins
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            sync_meta <= '0;
            sync_pins <= '0;
        end else begin
            sync_meta <= pins_in;
            sync_pins <= sync_meta;
        end
    end

    // ==============================
    // Read port
    // ==============================

    always_ff @(posedge clk) begin
        if (en) begin
            case (offset)
                gpio_out_offset: rd_data <= out_reg;
                gpio_in_offset:  rd_data <= sync_pins;
                gpio_dir_offset: rd_data <= dir_reg;
                default:         rd_data <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/system_bus.sv ====
// System bus decode and arbitration

`timescale 1ns/10ps
`default_nettype none

module system_bus
    import soc_bus_pkg::*;
(
    input  logic              clk,
    input  logic              rstz,
    // Instruction fetch port
    input  logic [xlen-1:0]   instr_addr,
    output logic [xlen-1:0]   instr_data,
    input  logic              instr_req,
    output logic              instr_gnt,
    // Data port
    input  logic [xlen-1:0]   data_addr,
    output logic [xlen-1:0]   data_rd_data,
    input  logic [xlen-1:0]   data_wr_data,
    input  logic [xlen/8-1:0] data_wr_mask,
    input  logic              data_rd_req,
    input  logic              data_wr_req,
    output logic              data_gnt,
    // Main memory side
    output logic [xlen-1:0]   mem_addr,
    input  logic [xlen-1:0]   mem_rd_data,
    output logic [xlen-1:0]   mem_wr_data,
    output logic              mem_en,
    output logic              mem_wr_en,
    output logic [xlen/8-1:0] mem_wr_mask,
    // GPIO side
    output logic [xlen-1:0]   gpio_addr,
    input  logic [xlen-1:0]   gpio_rd_data,
    output logic [xlen-1:0]   gpio_wr_data,
    output logic              gpio_en,
    output logic              gpio_wr_en
);

    logic       is_system;
    logic [3:0] sub_block;

    logic mem_data_rd;
    logic mem_data_wr;
    logic mem_data_access;
    logic gpio_data_rd;
    logic gpio_data_wr;
    logic gpio_data_access;

    logic instr_gnt_q;
    logic mem_data_gnt_q;
    logic gpio_data_gnt_q;

    // ==============================
    // Address decode
    // ==============================

    assign is_system = data_addr[system_bit];
    assign sub_block = data_addr[11:8];

    assign mem_data_rd     = data_rd_req & ~is_system;
    assign mem_data_wr     = data_wr_req & ~is_system;
    assign mem_data_access = mem_data_rd | mem_data_wr;

    // Other sub-block codes fall through with no target
    assign gpio_data_rd     = data_rd_req & is_system & (sub_block == gpio_select);
    assign gpio_data_wr     = data_wr_req & is_system & (sub_block == gpio_select);
    assign gpio_data_access = gpio_data_rd | gpio_data_wr;

    // ==============================
    // Memory port steering
    // ==============================

    // Data wins the shared port, fetch waits a cycle
    always_comb begin
        mem_en      = instr_req | mem_data_access;
        mem_wr_en   = mem_data_wr;
        mem_addr    = mem_data_access ? data_addr : instr_addr;
        mem_wr_data = data_wr_data;
        mem_wr_mask = data_wr_mask;
    end

    // GPIO takes whole words only
    always_comb begin
        gpio_en      = gpio_data_access;
        gpio_wr_en   = gpio_data_wr;
        gpio_addr    = data_addr;
        gpio_wr_data = data_wr_data;
    end

    // ==============================
    // Grants and read return
    // ==============================

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            instr_gnt_q     <= 1'b0;
            mem_data_gnt_q  <= 1'b0;
            gpio_data_gnt_q <= 1'b0;
        end else begin
            instr_gnt_q     <= instr_req & ~mem_data_access;
            mem_data_gnt_q  <= mem_data_access;
            gpio_data_gnt_q <= gpio_data_access;
        end
    end

    assign instr_gnt  = instr_gnt_q;
    assign instr_data = mem_rd_data;
    assign data_gnt   = mem_data_gnt_q | gpio_data_gnt_q;

    // Memory is the default source
    assign data_rd_data = gpio_data_gnt_q ? gpio_rd_data : mem_rd_data;

endmodule

`default_nettype wire

// ==== hw/soc_top.sv ====
// Microcontroller memory fabric top

`timescale 1ns/10ps
`default_nettype none

module soc_top
    import soc_bus_pkg::*;
(
    input  logic              clk,
    input  logic              rstz,
    // Instruction fetch port
    input  logic [xlen-1:0]   instr_addr,
    input  logic              instr_req,
    output logic [xlen-1:0]   instr_data,
    output logic              instr_gnt,
    // Data port
    input  logic [xlen-1:0]   data_addr,
    input  logic [xlen-1:0]   data_wr_data,
    input  logic [xlen/8-1:0] data_wr_mask,
    input  logic              data_rd_req,
    input  logic              data_wr_req,
    output logic [xlen-1:0]   data_rd_data,
    output logic              data_gnt,
    // Board pins
    input  logic [xlen-1:0]   gpio_pins_in,
    output logic [xlen-1:0]   gpio_pins_out,
    output logic [xlen-1:0]   gpio_pins_oe
);

    // Memory link
    logic [xlen-1:0]   mem_addr;
    logic [xlen-1:0]   mem_wr_data;
    logic [xlen-1:0]   mem_rd_data;
    logic              mem_en;
    logic              mem_wr_en;
    logic [xlen/8-1:0] mem_wr_mask;

    // GPIO link
    logic [xlen-1:0]   gpio_addr;
    logic [xlen-1:0]   gpio_wr_data;
    logic [xlen-1:0]   gpio_rd_data;
    logic              gpio_en;
    logic              gpio_wr_en;

    system_bus u_system_bus (
        .clk          (clk),
        .rstz         (rstz),
        .instr_addr   (instr_addr),
        .instr_data   (instr_data),
        .instr_req    (instr_req),
        .instr_gnt    (instr_gnt),
        .data_addr    (data_addr),
        .data_rd_data (data_rd_data),
        .data_wr_data (data_wr_data),
        .data_wr_mask (data_wr_mask),
        .data_rd_req  (data_rd_req),
        .data_wr_req  (data_wr_req),
        .data_gnt     (data_gnt),
        .mem_addr     (mem_addr),
        .mem_rd_data  (mem_rd_data),
        .mem_wr_data  (mem_wr_data),
        .mem_en       (mem_en),
        .mem_wr_en    (mem_wr_en),
        .mem_wr_mask  (mem_wr_mask),
        .gpio_addr    (gpio_addr),
        .gpio_rd_data (gpio_rd_data),
        .gpio_wr_data (gpio_wr_data),
        .gpio_en      (gpio_en),
        .gpio_wr_en   (gpio_wr_en)
    );

    main_memory u_main_memory (
        .clk     (clk),
        .addr    (mem_addr),
        .wr_data (mem_wr_data),
        .en      (mem_en),
        .wr_en   (mem_wr_en),
        .wr_mask (mem_wr_mask),
        .rd_data (mem_rd_data)
    );

    gpio_block u_gpio_block (
        .clk      (clk),
        .rstz     (rstz),
        .addr     (gpio_addr),
        .wr_data  (gpio_wr_data),
        .en       (gpio_en),
        .wr_en    (gpio_wr_en),
        .pins_in  (gpio_pins_in),
        .rd_data  (gpio_rd_data),
        .pins_out (gpio_pins_out),
        .pins_oe  (gpio_pins_oe)
    );

endmodule

`default_nettype wire

// ==== verification/soc_top_asserts.sv ====
// Grant timing checks for the system bus

`timescale 1ns/10ps
`default_nettype none

module soc_top_asserts
    import soc_bus_pkg::*;
(
    input logic            clk,
    input logic            rstz,
    input logic            instr_req,
    input logic            instr_gnt,
    input logic [xlen-1:0] data_addr,
    input logic            data_rd_req,
    input logic            data_wr_req,
    input logic            data_gnt
);

    int failures = 0;

    logic data_req;
    logic mem_req;
    logic gpio_req;

    assign data_req = data_rd_req | data_wr_req;
    assign mem_req  = data_req & ~data_addr[system_bit];
    assign gpio_req = data_req & data_addr[system_bit] & (data_addr[11:8] == gpio_select);

    // Grants are clear one edge into reset
    assert property (@(posedge clk) !rstz |=> !instr_gnt && !data_gnt)
        else begin
            failures++;
            $error("Grant high after reset was applied");
        end

    // Data requests to memory or GPIO are granted on the next cycle
    assert property (@(posedge clk) disable iff (!rstz) mem_req || gpio_req |=> data_gnt)
        else begin
            failures++;
            $error("Data request missed its grant");
        end

    // Idle port and unused sub-blocks never see a grant
    assert property (@(posedge clk) disable iff (!rstz) !mem_req && !gpio_req |=> !data_gnt)
        else begin
            failures++;
            $error("Data grant without a mapped request");
        end

    // Fetch waits while data owns the memory
    assert property (@(posedge clk) disable iff (!rstz) instr_req && mem_req |=> !instr_gnt)
        else begin
            failures++;
            $error("Fetch granted during a memory data access");
        end

    assert property (@(posedge clk) disable iff (!rstz) instr_req && !mem_req |=> instr_gnt)
        else begin
            failures++;
            $error("Fetch on a free memory port missed its grant");
        end

    assert property (@(posedge clk) disable iff (!rstz) !instr_req |=> !instr_gnt)
        else begin
            failures++;
            $error("Fetch grant without a request");
        end

endmodule

bind system_bus soc_top_asserts u_bus_asserts (
    .clk         (clk),
    .rstz        (rstz),
    .instr_req   (instr_req),
    .instr_gnt   (instr_gnt),
    .data_addr   (data_addr),
    .data_rd_req (data_rd_req),
    .data_wr_req (data_wr_req),
    .data_gnt    (data_gnt)
);

`default_nettype wire

// ==== verification/soc_top_tb.sv ====
// Memory fabric testbench

`timescale 1ns/10ps
`default_nettype none

module soc_top_tb
    import soc_bus_pkg::*;
();

    localparam int clk_period      = 4;
    localparam int init_words      = 32;
    localparam int random_ops      = 200;
    localparam int priority_rounds = 6;
    localparam int block_cycles    = 5;
    localparam int gpio_rounds     = 4;
    localparam int gnt_wait_limit  = 8;
    localparam int margin_ns       = 400;
    localparam logic [31:0] seed   = 32'h17c1d067;

    // Rough cycle budget, three cycles per bus access
    localparam int total_cycles = 8 + (init_words + random_ops) * 3
                                + priority_rounds * (block_cycles + 8)
                                + gpio_rounds * 24 + 48;

    logic              clk;
    logic              rstz;
    logic [xlen-1:0]   instr_addr;
    logic              instr_req;
    logic [xlen-1:0]   instr_data;
    logic              instr_gnt;
    logic [xlen-1:0]   data_addr;
    logic [xlen-1:0]   data_wr_data;
    logic [xlen/8-1:0] data_wr_mask;
    logic              data_rd_req;
    logic              data_wr_req;
    logic [xlen-1:0]   data_rd_data;
    logic              data_gnt;
    logic [xlen-1:0]   gpio_pins_in;
    logic [xlen-1:0]   gpio_pins_out;
    logic [xlen-1:0]   gpio_pins_oe;

    // Reference state
    logic [xlen-1:0] model [init_words];
    logic [xlen-1:0] gpio_out_exp;
    logic [xlen-1:0] gpio_dir_exp;
    logic [31:0]     rng_state = seed;

    int errors = 0;
    int checks = 0;
    int tests  = 0;

    soc_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // ==============================
    // Helpers
    // ==============================

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Test slots spread over the whole memory, word index = slot * 32
    function automatic logic [31:0] slot_addr(input logic [4:0] slot);
        return {20'h0, slot, 7'h0};
    endfunction

    function automatic logic [31:0] gpio_word_addr(input logic [5:0] offset);
        return {19'h0, 1'b1, 4'h0, offset, 2'b00};
    endfunction

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic apply_write(input logic [4:0] slot, input logic [31:0] wdata,
                               input logic [3:0] mask);
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                model[slot][8*b +: 8] = wdata[8*b +: 8];
            end
        end
    endtask

    // Holds one data request until its grant and returns the read data
    task automatic bus_access(input logic write, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic [3:0] mask,
                              output logic [31:0] rdata);
        int waited;
        @(posedge clk);
        data_addr    <= addr;
        data_wr_data <= wdata;
        data_wr_mask <= mask;
        data_rd_req  <= ~write;
        data_wr_req  <= write;
        @(posedge clk);
        @(negedge clk);
        waited = 0;
        while (!data_gnt && waited < gnt_wait_limit) begin
            @(negedge clk);
            waited++;
        end
        if (!data_gnt) begin
            $display("Data access to %h at %0t was never granted", addr, $time);
            errors++;
        end
        rdata = data_rd_data;
    endtask

    task automatic release_bus();
        @(posedge clk);
        data_rd_req <= 1'b0;
        data_wr_req <= 1'b0;
        instr_req   <= 1'b0;
    endtask

    // Request to a missing sub-block, held for four cycles with no grant
    task automatic hold_unused(input logic write, input logic [31:0] addr,
                               input logic [31:0] wdata);
        @(posedge clk);
        data_addr    <= addr;
        data_wr_data <= wdata;
        data_wr_mask <= 4'hf;
        data_rd_req  <= ~write;
        data_wr_req  <= write;
        @(posedge clk);
        repeat (4) begin
            @(negedge clk);
            check_equal("data_gnt", 32'(data_gnt), 32'd0);
        end
    endtask

    task automatic log_test_done(input string name, input int err_start);
        tests++;
        $display("Test %s done at %0t with %0d errors", name, $time, errors - err_start);
    endtask

    // ==============================
    // Tests
    // ==============================

    task automatic reset_state();
        int err_start;
        err_start = errors;
        repeat (2) begin
            @(negedge clk);
            check_equal("instr_gnt", 32'(instr_gnt), 32'd0);
            check_equal("data_gnt", 32'(data_gnt), 32'd0);
            check_equal("gpio_pins_out", gpio_pins_out, 32'd0);
            check_equal("gpio_pins_oe", gpio_pins_oe, 32'd0);
        end
        log_test_done("reset state", err_start);
    endtask

    task automatic random_memory();
        int          err_start;
        logic [31:0] r;
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic [4:0]  slot;
        err_start = errors;
        // Fill every slot so later reads never see unwritten words
        for (int s = 0; s < init_words; s++) begin
            slot  = 5'(s);
            wdata = next_random();
            bus_access(1'b1, slot_addr(slot), wdata, 4'hf, rdata);
            apply_write(slot, wdata, 4'hf);
        end
        for (int i = 0; i < random_ops; i++) begin
            r    = next_random();
            slot = r[4:0];
            if (r[5]) begin
                wdata = next_random();
                bus_access(1'b1, slot_addr(slot), wdata, r[11:8], rdata);
                apply_write(slot, wdata, r[11:8]);
            end else begin
                bus_access(1'b0, slot_addr(slot), 32'h0, 4'h0, rdata);
                check_equal("data_rd_data", rdata, model[slot]);
            end
        end
        release_bus();
        log_test_done("random memory", err_start);
    endtask

    task automatic data_priority();
        int         err_start;
        int         waited;
        logic [4:0] fetch_slot;
        logic [4:0] data_slot;
        err_start = errors;
        for (int round = 0; round < priority_rounds; round++) begin
            fetch_slot = 5'(next_random() % 32);
            data_slot  = 5'(next_random() % 32);
            @(posedge clk);
            instr_addr  <= slot_addr(fetch_slot);
            instr_req   <= 1'b1;
            data_addr   <= slot_addr(data_slot);
            data_rd_req <= 1'b1;
            data_wr_req <= 1'b0;
            @(posedge clk);
            repeat (block_cycles) begin
                @(negedge clk);
                check_equal("instr_gnt", 32'(instr_gnt), 32'd0);
                check_equal("data_rd_data", data_rd_data, model[data_slot]);
            end
            @(posedge clk);
            data_rd_req <= 1'b0;
            @(posedge clk);
            @(negedge clk);
            waited = 0;
            while (!instr_gnt && waited < gnt_wait_limit) begin
                @(negedge clk);
                waited++;
            end
            if (!instr_gnt) begin
                $display("Fetch held at %0t was never granted after data stopped", $time);
                errors++;
            end else begin
                check_equal("instr_data", instr_data, model[fetch_slot]);
            end
            release_bus();
        end
        log_test_done("data priority", err_start);
    endtask

    task automatic gpio_registers();
        int          err_start;
        logic [31:0] value;
        logic [31:0] rdata;
        logic [5:0]  offset;
        err_start = errors;
        for (int round = 0; round < gpio_rounds; round++) begin
            gpio_out_exp = next_random();
            bus_access(1'b1, gpio_word_addr(gpio_out_offset), gpio_out_exp, 4'hf, rdata);
            check_equal("gpio_pins_out", gpio_pins_out, gpio_out_exp);
            bus_access(1'b0, gpio_word_addr(gpio_out_offset), 32'h0, 4'h0, rdata);
            check_equal("data_rd_data", rdata, gpio_out_exp);

            gpio_dir_exp = next_random();
            bus_access(1'b1, gpio_word_addr(gpio_dir_offset), gpio_dir_exp, 4'hf, rdata);
            check_equal("gpio_pins_oe", gpio_pins_oe, gpio_dir_exp);
            bus_access(1'b0, gpio_word_addr(gpio_dir_offset), 32'h0, 4'h0, rdata);
            check_equal("data_rd_data", rdata, gpio_dir_exp);

            // Input pins pass two sync flops before they are readable
            value = next_random();
            @(posedge clk);
            gpio_pins_in <= value;
            repeat (3) @(posedge clk);
            bus_access(1'b0, gpio_word_addr(gpio_in_offset), 32'h0, 4'h0, rdata);
            check_equal("data_rd_data", rdata, value);

            offset = 6'(3 + (next_random() % 61));
            bus_access(1'b0, gpio_word_addr(offset), 32'h0, 4'h0, rdata);
            check_equal("data_rd_data", rdata, 32'h0);
        end
        release_bus();
        log_test_done("gpio registers", err_start);
    endtask

    task automatic unused_subblock();
        int          err_start;
        logic [31:0] rdata;
        err_start = errors;
        // 0x1100 aliases slot 2 and the output register, 0x1208 the enable register
        hold_unused(1'b1, 32'h0000_1100, ~gpio_out_exp);
        hold_unused(1'b1, 32'h0000_1208, ~gpio_dir_exp);
        hold_unused(1'b0, 32'h0000_1f04, 32'h0);
        release_bus();
        bus_access(1'b0, slot_addr(5'd2), 32'h0, 4'h0, rdata);
        check_equal("data_rd_data", rdata, model[2]);
        bus_access(1'b0, gpio_word_addr(gpio_out_offset), 32'h0, 4'h0, rdata);
        check_equal("data_rd_data", rdata, gpio_out_exp);
        bus_access(1'b0, gpio_word_addr(gpio_dir_offset), 32'h0, 4'h0, rdata);
        check_equal("data_rd_data", rdata, gpio_dir_exp);
        check_equal("gpio_pins_out", gpio_pins_out, gpio_out_exp);
        check_equal("gpio_pins_oe", gpio_pins_oe, gpio_dir_exp);
        release_bus();
        log_test_done("unused sub-block", err_start);
    endtask

    // ==============================
    // Sequence and watchdog
    // ==============================

    initial begin
        int assert_fails;
        rstz         = 1'b0;
        instr_addr   = '0;
        instr_req    = 1'b0;
        data_addr    = '0;
        data_wr_data = '0;
        data_wr_mask = '0;
        data_rd_req  = 1'b0;
        data_wr_req  = 1'b0;
        gpio_pins_in = '0;
        gpio_out_exp = '0;
        gpio_dir_exp = '0;
        repeat (2) @(posedge clk);
        rstz <= 1'b1;

        reset_state();
        random_memory();
        data_priority();
        gpio_registers();
        unused_subblock();

        repeat (2) @(posedge clk);
        assert_fails = UUT.u_system_bus.u_bus_asserts.failures;
        $display("Tests %0d, checks %0d, check errors %0d, assertion failures %0d",
                 tests, checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(total_cycles * clk_period + margin_ns);
        $display("Watchdog expired at %0t before the tests finished", $time);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
hw/soc_bus_pkg.sv
hw/main_memory.sv
hw/gpio_block.sv
hw/system_bus.sv
hw/soc_top.sv
verification/soc_top_asserts.sv
verification/soc_top_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the fabric testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module soc_top_tb -Mdir "$build_dir" -f sources.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Keep running past assertion errors so the testbench can report them
"./$build_dir/Vsoc_top_tb" +verilator+error+limit+1000 > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Everything OK$" "$log_file"; then
    exit 0
fi
echo "Pass line not found in $log_file"
exit 1
